//--- Makefile
# Verilator build and run of the slm control path testbench

SIM  := obj_dir/Vslm_ctrl_tb
SRCS := $(wildcard source/*.sv tests/*.sv)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): tb.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/100ps \
	  --top-module slm_ctrl_tb -f tb.f

# status comes from the search for the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

//--- source/cmd_assembler.sv
`timescale 1ns/100ps
// command assembler
// pairs received bytes into address/data words and flags stream commands
module cmd_assembler import uart_pkg::*, spi_pkg::*; (
  input  logic                  fpga_clk,
  input  logic                  reset_all_cmd_w,
  input  logic [BYTE_W-1:0]     rx_byte_i,
  input  logic                  rx_strobe_i,
  output logic                  cmd_valid_o,
  input  logic                  cmd_ready_i,
  output logic [SPI_WORD_W-1:0] cmd_word_o,
  output logic                  cmd_stream_o
);

  // high while the address byte of a pair is held
  logic                  odd_q;
  logic [BYTE_W-1:0]     addr_q;
  logic                  valid_q;
  logic [SPI_WORD_W-1:0] word_q;
  logic                  stream_q;

  logic pair_done;

  // second byte of a pair has just arrived
  assign pair_done = rx_strobe_i && odd_q;

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      odd_q   <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      // byte parity flips on every received byte
      if (rx_strobe_i) begin
        odd_q <= ~odd_q;
      end
      // a new pair wins over the drop of a taken one
      if (pair_done) begin
        valid_q <= 1'b1;
      end else if (valid_q && cmd_ready_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // byte pairing

  // word only reloads on a completed pair so it stays stable while pending
  always_ff @(posedge fpga_clk) begin
    if (rx_strobe_i && !odd_q) begin
      addr_q <= rx_byte_i;
    end
    if (pair_done) begin
      // address goes out first
      word_q   <= {addr_q, rx_byte_i};
      stream_q <= (addr_q == op_stream);
    end
  end

  assign cmd_valid_o  = valid_q;
  assign cmd_word_o   = word_q;
  assign cmd_stream_o = stream_q;

  // the spi master must have taken the last pair before the next completes
  a_no_overrun: assert property (@(posedge fpga_clk) disable iff (reset_all_cmd_w)
    pair_done |-> (!cmd_valid_o || cmd_ready_i))
    else $error("cmd_assembler overrun, pending command replaced");

endmodule

//--- source/reply_fifo.sv
`timescale 1ns/100ps
// reply fifo
// small circular buffer of reply bytes between the spi master and uart tx
module reply_fifo import uart_pkg::*; #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic              fpga_clk,
  input  logic              reset_all_cmd_w,
  input  logic              wr_valid_i,
  output logic              wr_ready_o,
  input  logic [BYTE_W-1:0] wr_byte_i,
  output logic              rd_valid_o,
  input  logic              rd_ready_i,
  output logic [BYTE_W-1:0] rd_byte_o
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [BYTE_W-1:0] mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  count_q;

  logic do_wr;
  logic do_rd;

  // wrap for depths that are not a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign wr_ready_o = (count_q != CNT_W'(FIFO_DEPTH));
  assign rd_valid_o = (count_q != '0);
  assign do_wr      = wr_valid_i && wr_ready_o;
  assign do_rd      = rd_valid_o && rd_ready_i;

  //////////////////////////////////////////////////
  // pointers and occupancy

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_rd) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({do_wr, do_rd})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge fpga_clk) begin
    if (do_wr) begin
      mem_q[wr_ptr_q] <= wr_byte_i;
    end
  end

  // head entry shown directly
  assign rd_byte_o = mem_q[rd_ptr_q];

  // at equal baud rates the spi side never finds the fifo full
  a_no_full_write: assert property (@(posedge fpga_clk) disable iff (reset_all_cmd_w)
    wr_valid_i |-> wr_ready_o)
    else $error("reply_fifo write offered while full");

  // head stays put until the transmitter takes it
  a_head_stable: assert property (@(posedge fpga_clk) disable iff (reset_all_cmd_w)
    (rd_valid_o && !rd_ready_i) |=> (rd_valid_o && $stable(rd_byte_o)))
    else $error("reply_fifo head changed before read");

endmodule

//--- source/slm_ctrl_top.sv
`timescale 1ns/100ps
// slm board serial control path
// host uart bytes become spi register writes, spi replies return over uart
module slm_ctrl_top import uart_pkg::*, spi_pkg::*; #(
  parameter int CLKS_PER_BIT = CLKS_PER_BIT_DEF,
  parameter int SCK_HALF     = SCK_HALF_DEF,
  parameter int FIFO_DEPTH   = 4
) (
  input  logic fpga_clk,
  input  logic reset_all_cmd_w,
  input  logic uart_rx_i,
  output logic uart_tx_o,
  input  logic sout_i,
  output logic sen_o,
  output logic sck_o,
  output logic sdat_o
);

  // uart rx to assembler
  logic [BYTE_W-1:0]     rx_byte;
  logic                  rx_strobe;
  // assembler to spi
  logic                  cmd_valid;
  logic                  cmd_ready;
  logic [SPI_WORD_W-1:0] cmd_word;
  logic                  cmd_stream;
  // spi to reply fifo
  logic                  reply_valid;
  logic                  reply_ready;
  logic [BYTE_W-1:0]     reply_byte;
  // reply fifo to uart tx
  logic                  tx_valid;
  logic                  tx_ready;
  logic [BYTE_W-1:0]     tx_byte;

  //////////////////////////////////////////////////
  // host to display

  uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart_rx (
    .fpga_clk       (fpga_clk),
    .reset_all_cmd_w(reset_all_cmd_w),
    .rx_serial_i    (uart_rx_i),
    .rx_byte_o      (rx_byte),
    .rx_strobe_o    (rx_strobe)
  );

  cmd_assembler i_cmd_assembler (
    .fpga_clk       (fpga_clk),
    .reset_all_cmd_w(reset_all_cmd_w),
    .rx_byte_i      (rx_byte),
    .rx_strobe_i    (rx_strobe),
    .cmd_valid_o    (cmd_valid),
    .cmd_ready_i    (cmd_ready),
    .cmd_word_o     (cmd_word),
    .cmd_stream_o   (cmd_stream)
  );

  spi_master #(.SCK_HALF(SCK_HALF)) i_spi_master (
    .fpga_clk       (fpga_clk),
    .reset_all_cmd_w(reset_all_cmd_w),
    .cmd_valid_i    (cmd_valid),
    .cmd_ready_o    (cmd_ready),
    .cmd_word_i     (cmd_word),
    .cmd_stream_i   (cmd_stream),
    .reply_valid_o  (reply_valid),
    .reply_ready_i  (reply_ready),
    .reply_byte_o   (reply_byte),
    .sout_i         (sout_i),
    .sen_o          (sen_o),
    .sck_o          (sck_o),
    .sdat_o         (sdat_o)
  );

  //////////////////////////////////////////////////
  // replies back to host

  reply_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_reply_fifo (
    .fpga_clk       (fpga_clk),
    .reset_all_cmd_w(reset_all_cmd_w),
    .wr_valid_i     (reply_valid),
    .wr_ready_o     (reply_ready),
    .wr_byte_i      (reply_byte),
    .rd_valid_o     (tx_valid),
    .rd_ready_i     (tx_ready),
    .rd_byte_o      (tx_byte)
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) i_uart_tx (
    .fpga_clk       (fpga_clk),
    .reset_all_cmd_w(reset_all_cmd_w),
    .tx_valid_i     (tx_valid),
    .tx_ready_o     (tx_ready),
    .tx_byte_i      (tx_byte),
    .tx_serial_o    (uart_tx_o)
  );

endmodule

//--- source/spi_master.sv
`timescale 1ns/100ps
// spi master for the display register port
// shifts a 16-bit command out msb first and captures the reply byte
module spi_master import uart_pkg::*, spi_pkg::*; #(
  parameter int SCK_HALF = SCK_HALF_DEF
) (
  input  logic                  fpga_clk,
  input  logic                  reset_all_cmd_w,
  input  logic                  cmd_valid_i,
  output logic                  cmd_ready_o,
  input  logic [SPI_WORD_W-1:0] cmd_word_i,
  input  logic                  cmd_stream_i,
  output logic                  reply_valid_o,
  input  logic                  reply_ready_i,
  output logic [BYTE_W-1:0]     reply_byte_o,
  input  logic                  sout_i,
  output logic                  sen_o,
  output logic                  sck_o,
  output logic                  sdat_o
);

  localparam int DIV_W      = $clog2(SCK_HALF + 1);
  localparam int BIT_W      = $clog2(SPI_WORD_W);
  localparam int DATA_START = SPI_WORD_W - BYTE_W;

  spi_state_t            state_q;
  logic [DIV_W-1:0]      div_q;
  logic [BIT_W-1:0]      bit_q;
  logic [SPI_WORD_W-1:0] tx_q;
  logic [BYTE_W-1:0]     rx_q;
  logic                  stream_q;
  logic                  sen_q;
  logic                  sck_q;
  logic                  sdat_q;
  logic                  reply_valid_q;

  logic accept;
  logic half_done;
  logic last_bit;
  logic sck_rise;
  logic sck_fall;

  assign accept    = cmd_valid_i && cmd_ready_o;
  assign half_done = (div_q == DIV_W'(SCK_HALF - 1));
  assign last_bit  = (bit_q == BIT_W'(SPI_WORD_W - 1));
  // edges of sck as seen from the shift state
  assign sck_rise  = (state_q == spi_shift) && half_done && !sck_q;
  assign sck_fall  = (state_q == spi_shift) && half_done && sck_q;

  // busy from acceptance until the reply has gone to the fifo
  assign cmd_ready_o = (state_q == spi_idle);

  //////////////////////////////////////////////////
  // frame sequencing

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state_q       <= spi_idle;
      div_q         <= '0;
      bit_q         <= '0;
      stream_q      <= 1'b0;
      sen_q         <= 1'b1;
      sck_q         <= 1'b0;
      sdat_q        <= 1'b0;
      reply_valid_q <= 1'b0;
    end else begin
      if (reply_valid_q && reply_ready_i) begin
        reply_valid_q <= 1'b0;
      end
      case (state_q)
        spi_idle: begin
          if (accept) begin
            state_q  <= spi_shift;
            div_q    <= '0;
            bit_q    <= '0;
            stream_q <= cmd_stream_i;
            // sen may already be low after a stream command
            sen_q    <= 1'b0;
            // first bit ready before the first rising edge
            sdat_q   <= cmd_word_i[SPI_WORD_W-1];
          end
        end
        spi_shift: begin
          if (half_done) begin
            div_q <= '0;
            sck_q <= ~sck_q;
            if (sck_fall) begin
              if (last_bit) begin
                state_q <= spi_hold;
              end else begin
                bit_q  <= bit_q + 1'b1;
                sdat_q <= tx_q[SPI_WORD_W-2];
              end
            end else if (last_bit) begin
              // reply complete once the last bit is sampled
              reply_valid_q <= 1'b1;
            end
          end else begin
            div_q <= div_q + 1'b1;
          end
        end
        spi_hold: begin
          if (half_done) begin
            div_q <= '0;
            // stream frame leaves sen low for the next command
            if (!stream_q) begin
              sen_q <= 1'b1;
            end
            state_q <= reply_valid_q ? spi_reply : spi_idle;
          end else begin
            div_q <= div_q + 1'b1;
          end
        end
        spi_reply: begin
          // waits here while the fifo holds off
          if (!reply_valid_q || reply_ready_i) begin
            state_q <= spi_idle;
          end
        end
        default: state_q <= spi_idle;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // shift registers

  always_ff @(posedge fpga_clk) begin
    if (accept) begin
      tx_q <= cmd_word_i;
    end else if (sck_fall && !last_bit) begin
      tx_q <= {tx_q[SPI_WORD_W-2:0], 1'b0};
    end
    // only the data byte is captured
    if (sck_rise && bit_q >= BIT_W'(DATA_START)) begin
      rx_q <= {rx_q[BYTE_W-2:0], sout_i};
    end
  end

  assign reply_valid_o = reply_valid_q;
  assign reply_byte_o  = rx_q;
  assign sen_o         = sen_q;
  assign sck_o         = sck_q;
  assign sdat_o        = sdat_q;

  // the register port only sees clocks inside a frame
  a_sen_low_on_sck: assert property (@(posedge fpga_clk) disable iff (reset_all_cmd_w)
    sck_o |-> !sen_o)
    else $error("spi_master sck high while sen high");

  // data is launched on falling edges only
  a_sdat_stable: assert property (@(posedge fpga_clk) disable iff (reset_all_cmd_w)
    sck_o |-> $stable(sdat_o))
    else $error("spi_master sdat changed while sck high");

endmodule

//--- source/spi_pkg.sv
// display register port definitions
// word width, clock divider default, special address bytes and master states
package spi_pkg;

  //////////////////////////////////////////////////
  // widths and timing

  // address byte plus data byte
  localparam int SPI_WORD_W = 16;

  // fpga_clk cycles per half sck period
  localparam int SCK_HALF_DEF = 4;

  //////////////////////////////////////////////////
  // encodings

  // address bytes with a special meaning
  // op_stream keeps sen low into the next transfer
  typedef enum logic [7:0] {
    op_stream = 8'hBC
  } spi_opcode_t;

  // master sequencing
  // hold covers the trailing half period before sen may rise
  typedef enum logic [1:0] {
    spi_idle  = 2'd0,
    spi_shift = 2'd1,
    spi_hold  = 2'd2,
    spi_reply = 2'd3
  } spi_state_t;

endpackage

//--- source/uart_pkg.sv
// serial link definitions
// byte width, default bit period and the shared rx/tx state encoding
package uart_pkg;

  //////////////////////////////////////////////////
  // widths and timing

  // one serial byte
  localparam int BYTE_W = 8;

  // fpga_clk cycles per uart bit
  // 20 cycles keeps the bit period aligned with the spi clock
  localparam int CLKS_PER_BIT_DEF = 20;

  //////////////////////////////////////////////////
  // state encoding

  // used by both the receiver and the transmitter
  typedef enum logic [1:0] {
    uart_idle  = 2'd0,
    uart_start = 2'd1,
    uart_data  = 2'd2,
    uart_stop  = 2'd3
  } uart_state_t;

endpackage

//--- source/uart_rx.sv
`timescale 1ns/100ps
// uart receiver
// samples each bit at mid-period and strobes the received byte for one cycle
module uart_rx import uart_pkg::*; #(
  parameter int CLKS_PER_BIT = CLKS_PER_BIT_DEF
) (
  input  logic              fpga_clk,
  input  logic              reset_all_cmd_w,
  input  logic              rx_serial_i,
  output logic [BYTE_W-1:0] rx_byte_o,
  output logic              rx_strobe_o
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam int IDX_W = $clog2(BYTE_W);

  // two-flop synchronizer, line idles high
  logic rx_meta_q;
  logic rx_sync_q;

  uart_state_t       state_q;
  logic [CNT_W-1:0]  cnt_q;
  logic [IDX_W-1:0]  idx_q;
  logic [BYTE_W-1:0] byte_q;
  logic              strobe_q;

  logic half_bit;
  logic full_bit;

  // middle of the start bit, then one full bit per data/stop sample
  assign half_bit = (cnt_q == CNT_W'((CLKS_PER_BIT - 1) / 2));
  assign full_bit = (cnt_q == CNT_W'(CLKS_PER_BIT - 1));

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_serial_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  //////////////////////////////////////////////////
  // receive fsm

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state_q  <= uart_idle;
      cnt_q    <= '0;
      idx_q    <= '0;
      strobe_q <= 1'b0;
    end else begin
      // strobe is a single cycle pulse
      strobe_q <= 1'b0;
      case (state_q)
        uart_idle: begin
          cnt_q <= '0;
          idx_q <= '0;
          // falling edge on the line marks a start bit
          if (!rx_sync_q) begin
            state_q <= uart_start;
          end
        end
        uart_start: begin
          if (half_bit) begin
            cnt_q <= '0;
            // glitch shorter than half a bit goes back to idle
            state_q <= rx_sync_q ? uart_idle : uart_data;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        uart_data: begin
          if (full_bit) begin
            cnt_q <= '0;
            if (idx_q == IDX_W'(BYTE_W - 1)) begin
              state_q <= uart_stop;
            end else begin
              idx_q <= idx_q + 1'b1;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        uart_stop: begin
          if (full_bit) begin
            cnt_q <= '0;
            // only a high stop bit delivers the byte
            strobe_q <= rx_sync_q;
            state_q  <= uart_idle;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: state_q <= uart_idle;
      endcase
    end
  end

  // lsb arrives first, shift in from the top
  always_ff @(posedge fpga_clk) begin
    if (state_q == uart_data && full_bit) begin
      byte_q <= {rx_sync_q, byte_q[BYTE_W-1:1]};
    end
  end

  assign rx_byte_o   = byte_q;
  assign rx_strobe_o = strobe_q;

endmodule

//--- source/uart_tx.sv
`timescale 1ns/100ps
// uart transmitter
// takes a reply byte and sends start, 8 data bits lsb first and stop
module uart_tx import uart_pkg::*; #(
  parameter int CLKS_PER_BIT = CLKS_PER_BIT_DEF
) (
  input  logic              fpga_clk,
  input  logic              reset_all_cmd_w,
  input  logic              tx_valid_i,
  output logic              tx_ready_o,
  input  logic [BYTE_W-1:0] tx_byte_i,
  output logic              tx_serial_o
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT);
  localparam int IDX_W = $clog2(BYTE_W);

  uart_state_t       state_q;
  logic [CNT_W-1:0]  cnt_q;
  logic [IDX_W-1:0]  idx_q;
  logic [BYTE_W-1:0] data_q;
  logic              serial_q;

  logic bit_done;

  assign bit_done   = (cnt_q == CNT_W'(CLKS_PER_BIT - 1));
  assign tx_ready_o = (state_q == uart_idle);

  //////////////////////////////////////////////////
  // transmit fsm

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state_q  <= uart_idle;
      cnt_q    <= '0;
      idx_q    <= '0;
      serial_q <= 1'b1;
    end else begin
      case (state_q)
        uart_idle: begin
          cnt_q <= '0;
          idx_q <= '0;
          // start bit goes out on the next cycle
          if (tx_valid_i) begin
            serial_q <= 1'b0;
            state_q  <= uart_start;
          end
        end
        uart_start: begin
          if (bit_done) begin
            cnt_q    <= '0;
            serial_q <= data_q[0];
            state_q  <= uart_data;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        uart_data: begin
          if (bit_done) begin
            cnt_q <= '0;
            if (idx_q == IDX_W'(BYTE_W - 1)) begin
              serial_q <= 1'b1;
              state_q  <= uart_stop;
            end else begin
              idx_q    <= idx_q + 1'b1;
              serial_q <= data_q[1];
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        uart_stop: begin
          if (bit_done) begin
            cnt_q   <= '0;
            state_q <= uart_idle;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: state_q <= uart_idle;
      endcase
    end
  end

  // latched on transfer, bit 0 always holds the next bit out
  always_ff @(posedge fpga_clk) begin
    if (state_q == uart_idle && tx_valid_i) begin
      data_q <= tx_byte_i;
    end else if (state_q == uart_data && bit_done) begin
      data_q <= {1'b0, data_q[BYTE_W-1:1]};
    end
  end

  assign tx_serial_o = serial_q;

endmodule

//--- tb.f
source/uart_pkg.sv
source/spi_pkg.sv
source/uart_rx.sv
source/cmd_assembler.sv
source/spi_master.sv
source/reply_fifo.sv
source/uart_tx.sv
source/slm_ctrl_top.sv
tests/slm_ctrl_tb.sv

//--- tests/slm_ctrl_tb.sv
`timescale 1ns/100ps
// testbench for the slm serial control path
// uart host and spi register-port models drive the dut, assertions check the responses
module slm_ctrl_tb;

  //////////////////////////////////////////////////
  // timing and test sizes

  localparam int CLK_NS       = 100;
  localparam int CLKS_PER_BIT = 20;
  localparam int SCK_HALF     = 4;
  localparam int SPI_BITS     = 16;
  localparam logic [7:0] STREAM_ADDR = 8'hBC;
  localparam int N_RANDOM     = 6;
  // random pairs, the lone-byte pair and the two stream pairs
  localparam int N_PAIRS      = N_RANDOM + 3;
  localparam int BIT_NS       = CLKS_PER_BIT * CLK_NS;
  localparam int BYTE_NS      = 10 * BIT_NS;
  localparam int FRAME_NS     = (2 * SPI_BITS + 2) * SCK_HALF * CLK_NS;
  localparam int IDLE_NS      = 20 * BIT_NS;
  localparam int TEST_NS      = 2 * N_PAIRS * BYTE_NS + N_PAIRS * (FRAME_NS + BYTE_NS) + IDLE_NS;
  localparam int WATCHDOG_NS  = 2 * TEST_NS;
  // one frame plus one reply, with margin
  localparam int DRAIN_LIMIT  = 4 * (FRAME_NS + BYTE_NS) / CLK_NS;

  logic fpga_clk;
  logic reset_all_cmd_w;
  logic uart_rx_i;
  logic sout_i = 1'b0;
  logic uart_tx_o;
  logic sen_o;
  logic sck_o;
  logic sdat_o;

  // expected traffic, queued as pairs are sent
  logic [15:0] exp_frames[$];
  logic [7:0]  exp_replies[$];

  int   value_errors = 0;
  int   other_errors = 0;
  // high while no spi or uart activity is allowed
  logic quiet = 1'b1;

  // register-port model state
  logic [15:0] shift_q;
  logic [15:0] exp_word;
  logic [7:0]  addr_cur;
  int          bit_cnt;
  logic        sck_prev;
  logic        sen_prev;
  logic        release_due;
  logic        last_stream;

  slm_ctrl_top #(
    .CLKS_PER_BIT(CLKS_PER_BIT),
    .SCK_HALF    (SCK_HALF),
    .FIFO_DEPTH  (4)
  ) i_slm_ctrl_top (
    .fpga_clk       (fpga_clk),
    .reset_all_cmd_w(reset_all_cmd_w),
    .uart_rx_i      (uart_rx_i),
    .uart_tx_o      (uart_tx_o),
    .sout_i         (sout_i),
    .sen_o          (sen_o),
    .sck_o          (sck_o),
    .sdat_o         (sdat_o)
  );

  initial begin : clock_gen
    fpga_clk = 1'b0;
    forever begin
      #(CLK_NS / 2) fpga_clk = ~fpga_clk;
    end
  end

  //////////////////////////////////////////////////
  // reporting helpers

  task automatic log_mismatch(input string name, input int expected, input int actual);
    $display("CHECK FAILED time=%0t signal=%s expected=%0h actual=%0h",
             $time, name, expected, actual);
    value_errors++;
  endtask

  task automatic check_value(input string name, input int expected, input int actual);
    assert (expected == actual) else log_mismatch(name, expected, actual);
  endtask

  task automatic report_problem(input string msg);
    $display("ERROR time=%0t %s", $time, msg);
    other_errors++;
  endtask

  task automatic finish_run();
    $display("summary: %0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  endtask

  //////////////////////////////////////////////////
  // uart host model

  // start bit, 8 data bits lsb first, stop bit
  task automatic send_byte(input logic [7:0] value);
    uart_rx_i = 1'b0;
    repeat (CLKS_PER_BIT) @(negedge fpga_clk);
    for (int i = 0; i < 8; i++) begin
      uart_rx_i = value[i];
      repeat (CLKS_PER_BIT) @(negedge fpga_clk);
    end
    uart_rx_i = 1'b1;
    repeat (CLKS_PER_BIT) @(negedge fpga_clk);
  endtask

  // address then data on sdat, inverted address back on uart
  task automatic queue_frame(input logic [7:0] addr, input logic [7:0] data);
    exp_frames.push_back({addr, data});
    exp_replies.push_back(~addr);
  endtask

  task automatic send_pair(input logic [7:0] addr, input logic [7:0] data);
    queue_frame(addr, data);
    send_byte(addr);
    quiet = 1'b0;
    send_byte(data);
  endtask

  // all replies back, sen released, line idle
  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while ((exp_replies.size() != 0 || !uart_tx_o || !sen_o) && cycles < DRAIN_LIMIT) begin
      @(negedge fpga_clk);
      cycles++;
    end
    if (cycles >= DRAIN_LIMIT) begin
      report_problem("replies did not drain within the time limit");
    end
    // rest of the stop bit
    repeat (CLKS_PER_BIT) @(negedge fpga_clk);
  endtask

  //////////////////////////////////////////////////
  // spi register-port model

  // sampled on the falling clock, outputs are settled there
  always @(negedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      bit_cnt     = 0;
      sck_prev    = 1'b0;
      sen_prev    = 1'b1;
      release_due = 1'b0;
      last_stream = 1'b0;
      sout_i      = 1'b0;
    end else begin
      if (sck_o && !sck_prev) begin
        shift_q = {shift_q[14:0], sdat_o};
        bit_cnt++;
        if (bit_cnt == 1 && release_due) begin
          report_problem("sen_o did not rise between normal frames");
        end
        // address byte complete, data phase follows
        if (bit_cnt == 8) begin
          addr_cur = shift_q[7:0];
        end
        if (bit_cnt == SPI_BITS) begin
          if (exp_frames.size() == 0) begin
            report_problem("spi frame seen with no command pending");
            last_stream = 1'b0;
          end else begin
            exp_word = exp_frames.pop_front();
            check_value("sdat_o", int'(exp_word), int'(shift_q));
            last_stream = (exp_word[15:8] == STREAM_ADDR);
          end
          release_due = !last_stream;
          bit_cnt     = 0;
        end
      end
      if (sen_o && !sen_prev) begin
        if (bit_cnt != 0) begin
          report_problem("sen_o rose inside a frame");
        end
        if (last_stream) begin
          report_problem("sen_o rose right after a stream frame");
        end
        release_due = 1'b0;
      end
      // inverted address, msb first, during the data phase
      if (bit_cnt >= 8) begin
        sout_i = ~addr_cur[15 - bit_cnt];
      end else begin
        sout_i = 1'b0;
      end
      sck_prev = sck_o;
      sen_prev = sen_o;
    end
  end

  //////////////////////////////////////////////////
  // reply monitor on uart_tx_o

  initial begin : reply_monitor
    logic [7:0] rx_byte;
    logic [7:0] exp_byte;
    wait (!reset_all_cmd_w);
    forever begin
      @(negedge fpga_clk);
      if (!uart_tx_o) begin
        // middle of the start bit
        repeat (CLKS_PER_BIT / 2) @(negedge fpga_clk);
        check_value("uart_tx_o start", 0, int'(uart_tx_o));
        for (int i = 0; i < 8; i++) begin
          repeat (CLKS_PER_BIT) @(negedge fpga_clk);
          rx_byte[i] = uart_tx_o;
        end
        repeat (CLKS_PER_BIT) @(negedge fpga_clk);
        check_value("uart_tx_o stop", 1, int'(uart_tx_o));
        if (exp_replies.size() == 0) begin
          report_problem("reply byte on uart_tx_o with no frame pending");
        end else begin
          exp_byte = exp_replies.pop_front();
          check_value("uart_tx_o", int'(exp_byte), int'(rx_byte));
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // assertions

  quiet_sen: assert property (@(posedge fpga_clk) disable iff (reset_all_cmd_w)
    quiet |-> sen_o)
    else log_mismatch("sen_o", 1, int'($sampled(sen_o)));

  quiet_sck: assert property (@(posedge fpga_clk) disable iff (reset_all_cmd_w)
    quiet |-> !sck_o)
    else log_mismatch("sck_o", 0, int'($sampled(sck_o)));

  quiet_uart: assert property (@(posedge fpga_clk) disable iff (reset_all_cmd_w)
    quiet |-> uart_tx_o)
    else log_mismatch("uart_tx_o", 1, int'($sampled(uart_tx_o)));

  // every sck pulse falls inside a frame
  sck_in_frame: assert property (@(posedge fpga_clk) disable iff (reset_all_cmd_w)
    sck_o |-> !sen_o)
    else log_mismatch("sen_o", 0, int'($sampled(sen_o)));

  initial begin : watchdog
    #(WATCHDOG_NS);
    report_problem("watchdog expired before the stimulus completed");
    finish_run();
  end

  //////////////////////////////////////////////////
  // stimulus

  initial begin : stimulus
    logic [7:0] addr;
    logic [7:0] data;
    void'($urandom(32'h325086dc));
    reset_all_cmd_w = 1'b1;
    uart_rx_i       = 1'b1;
    repeat (3) @(negedge fpga_clk);
    reset_all_cmd_w = 1'b0;
    // idle outputs before any pair
    repeat (5 * CLKS_PER_BIT) @(negedge fpga_clk);

    // random pairs, address kept off the stream opcode
    for (int i = 0; i < N_RANDOM; i++) begin
      addr = 8'($urandom);
      if (addr == STREAM_ADDR) begin
        addr = ~addr;
      end
      data = 8'($urandom);
      send_pair(addr, data);
    end
    wait_drained();

    // lone byte then long idle, pair completes later
    addr = 8'($urandom);
    if (addr == STREAM_ADDR) begin
      addr = ~addr;
    end
    data  = 8'($urandom);
    quiet = 1'b1;
    queue_frame(addr, data);
    send_byte(addr);
    repeat (12 * CLKS_PER_BIT) @(negedge fpga_clk);
    quiet = 1'b0;
    send_byte(data);
    wait_drained();

    // stream pair holds sen across the next one
    send_pair(STREAM_ADDR, 8'($urandom));
    addr = 8'($urandom);
    if (addr == STREAM_ADDR) begin
      addr = ~addr;
    end
    send_pair(addr, 8'($urandom));
    wait_drained();

    check_value("sen_o", 1, int'(sen_o));
    if (exp_frames.size() != 0) begin
      report_problem("some sent pairs never appeared as spi frames");
    end
    finish_run();
  end

endmodule
